// File: source/arb_pkg.sv
package arb_pkg;

    // ========================================================================
    // Subsystem sizing
    // ========================================================================

    // Clients sharing the output port
    localparam int NUM_CLIENTS = 8;

    // Payload carried by each client
    localparam int DATA_W = 16;

    // Bits needed to name one client
    localparam int CLIENT_IDX_W = $clog2(NUM_CLIENTS);

    // ========================================================================
    // Types
    // ========================================================================

    // One bit per client, for requests, masks and grants
    typedef logic [NUM_CLIENTS-1:0] client_vec_t;

    // Index of a single client
    typedef logic [CLIENT_IDX_W-1:0] client_idx_t;

    // Payload word of a single client
    typedef logic [DATA_W-1:0] client_data_t;

endpackage : arb_pkg

// File: source/leading_one_detector.sv
module leading_one_detector #(
    parameter int WIDTH = 8
)
(
    data,
    position,
    found
);

    // ========================================================================
    // Sizing
    // ========================================================================

    // Index width, kept at one bit for a degenerate single-bit input
    localparam int POS_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    input  logic [WIDTH-1:0] data;
    output logic [POS_W-1:0] position;
    output logic             found;

    // ========================================================================
    // Search
    // ========================================================================

    // Walk from bit 0 upwards
    // Every later hit overwrites, so the highest set bit is what remains
    always_comb
    begin
        position = '0;
        found    = 1'b0;
        for (int i = 0; i < WIDTH; i++)
        begin
            if (data[i])
            begin
                position = POS_W'(i);
                found    = 1'b1;
            end
        end
    end

    // All-zero input leaves position at zero and found low

endmodule : leading_one_detector

// File: source/round_robin_arbiter.sv
module round_robin_arbiter
    import arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  client_vec_t req,
    output client_vec_t gnt
);

    // ========================================================================
    // Declarations
    // ========================================================================

    // Clients strictly below the previous winner
    client_vec_t lower_mask;
    // Everyone except the previous winner
    client_vec_t excl_mask;

    // Candidate sets for the two searches
    client_vec_t req_masked;
    client_vec_t req_wide;
    logic        multi_req;

    // Search results
    client_idx_t masked_pos;
    logic        masked_found;
    client_idx_t wide_pos;
    logic        wide_found;

    // Arbitration result for this cycle
    client_idx_t winner;
    logic        win_vld;
    client_vec_t winner_onehot;

    // ========================================================================
    // Candidate sets
    // ========================================================================

    // Lower-priority requests continue the rotation downwards
    assign req_masked = req & lower_mask;

    // More than one bit set when clearing the lowest set bit leaves something
    assign multi_req = |(req & (req - client_vec_t'(1)));

    // With a lone requester the exclusion is skipped so it wins every cycle
    assign req_wide = multi_req ? (req & excl_mask) : req;

    // ========================================================================
    // Highest-set-bit searches
    // ========================================================================

    leading_one_detector #(
        .WIDTH (NUM_CLIENTS)
    ) u_masked_lod (
        .data     (req_masked),
        .position (masked_pos),
        .found    (masked_found)
    );

    leading_one_detector #(
        .WIDTH (NUM_CLIENTS)
    ) u_wide_lod (
        .data     (req_wide),
        .position (wide_pos),
        .found    (wide_found)
    );

    // ========================================================================
    // Winner selection
    // ========================================================================

    // Masked hit first, otherwise start over from the top of the wide set
    always_comb
    begin
        if (masked_found)
        begin
            winner  = masked_pos;
            win_vld = 1'b1;
        end
        else if (wide_found)
        begin
            winner  = wide_pos;
            win_vld = 1'b1;
        end
        else
        begin
            winner  = '0;
            win_vld = 1'b0;
        end
    end

    assign winner_onehot = client_vec_t'(1) << winner;

    // ========================================================================
    // Priority state
    // ========================================================================

    // Exclusion resets to all ones so the very first grant is never blocked
    // An idle cycle drops the last winner and priority restarts at the top
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lower_mask <= '0;
            excl_mask  <= '1;
        end
        else if (win_vld)
        begin
            lower_mask <= winner_onehot - client_vec_t'(1);
            excl_mask  <= ~winner_onehot;
        end
        else
        begin
            lower_mask <= '0;
            excl_mask  <= '1;
        end
    end

    // ========================================================================
    // Grant register
    // ========================================================================

    // One-cycle one-hot pulse per win
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gnt <= '0;
        end
        else
        begin
            gnt <= win_vld ? winner_onehot : '0;
        end
    end

    // ========================================================================
    // Assertions
    // ========================================================================

    // A grant only goes to a client that requested on the sampling edge
    a_gnt_requested: assert property (
        @(posedge clk) disable iff (!rst_n)
        (gnt & ~$past(req)) == '0
    );

endmodule : round_robin_arbiter

// File: source/grant_data_mux.sv
module grant_data_mux
    import arb_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  client_vec_t                   gnt,
    input  logic [NUM_CLIENTS*DATA_W-1:0] req_data,
    output logic                          out_valid,
    output client_idx_t                   out_client,
    output client_data_t                  out_data
);

    // ========================================================================
    // Declarations
    // ========================================================================

    client_idx_t  gnt_idx;
    logic         gnt_found;
    client_data_t sel_data;

    // ========================================================================
    // Grant decode and payload select
    // ========================================================================

    // Grant is one-hot, so its highest set bit is the granted client
    leading_one_detector #(
        .WIDTH (NUM_CLIENTS)
    ) u_gnt_lod (
        .data     (gnt),
        .position (gnt_idx),
        .found    (gnt_found)
    );

    // Client k sits in slice k of the flat payload bus
    assign sel_data = req_data[gnt_idx*DATA_W +: DATA_W];

    // ========================================================================
    // Output register
    // ========================================================================

    // Valid strobes for one cycle per grant
    // Index and payload hold their last values between grants
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid  <= 1'b0;
            out_client <= '0;
            out_data   <= '0;
        end
        else
        begin
            out_valid <= gnt_found;
            if (gnt_found)
            begin
                out_client <= gnt_idx;
                out_data   <= sel_data;
            end
        end
    end

    // ========================================================================
    // Assertions
    // ========================================================================

    // Each grant cycle is followed by exactly one output strobe
    a_valid_follows_gnt: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(|gnt)
    );

endmodule : grant_data_mux

// File: source/shared_port_arbiter.sv
module shared_port_arbiter
    import arb_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    // Client side
    input  client_vec_t                   req,
    input  logic [NUM_CLIENTS*DATA_W-1:0] req_data,

    // Grant pulses back to the clients
    output client_vec_t                   gnt,

    // Shared output port
    output logic                          out_valid,
    output client_idx_t                   out_client,
    output client_data_t                  out_data
);

    // ========================================================================
    // Pipeline
    // ========================================================================

    // Stage 1 picks a winner and registers its one-hot grant
    round_robin_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .gnt   (gnt)
    );

    // Stage 2 forwards the granted payload with its index
    // Payload is taken as presented during the grant cycle
    grant_data_mux u_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .gnt        (gnt),
        .req_data   (req_data),
        .out_valid  (out_valid),
        .out_client (out_client),
        .out_data   (out_data)
    );

    // Two cycles from request sample to output strobe
    // One item sits in gnt and one in the output register

endmodule : shared_port_arbiter

// File: verification/tb_shared_port_arbiter.sv
module tb_shared_port_arbiter
    import arb_pkg::*;
();

    localparam int MAX_CYCLES = 600;
    localparam int FLAT_W     = NUM_CLIENTS * DATA_W;

    logic              clk;
    logic              rst_n;
    client_vec_t       req;
    logic [FLAT_W-1:0] req_data;
    client_vec_t       gnt;
    logic              out_valid;
    client_idx_t       out_client;
    client_data_t      out_data;

    // Reference model state
    logic         have_last;
    client_idx_t  last_winner;
    client_vec_t  pred_gnt;
    client_vec_t  exp_gnt;
    logic         exp_valid;
    client_idx_t  exp_client;
    client_data_t exp_data;

    // Bookkeeping
    string       test_name;
    int          error_count = 0;
    int          errors_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'h951b;

    shared_port_arbiter u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_data   (req_data),
        .gnt        (gnt),
        .out_valid  (out_valid),
        .out_client (out_client),
        .out_data   (out_data)
    );

    // ========================================================================
    // Clock and run limit
    // ========================================================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Longest legal run is well under the limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES)
        begin
            $display("Run timed out after %0d cycles before all tests finished", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Position of the single bit in a one-hot vector
    function automatic client_idx_t index_of(input client_vec_t v);
        client_idx_t idx;
        idx = '0;
        for (int i = 0; i < NUM_CLIENTS; i++)
        begin
            if (v[i])
            begin
                idx = client_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // Below the last winner first, then highest other than the last winner,
    // a lone requester always wins
    function automatic client_vec_t predict_grant(input client_vec_t r, input logic hl,
                                                  input client_idx_t lw);
        int pick;
        int count;
        pick  = -1;
        count = 0;
        for (int i = 0; i < NUM_CLIENTS; i++)
        begin
            count += int'(r[i]);
            if (hl && r[i] && i < int'(lw))
            begin
                pick = i;
            end
        end
        if (pick < 0)
        begin
            for (int i = 0; i < NUM_CLIENTS; i++)
            begin
                if (r[i] && !(hl && count > 1 && i == int'(lw)))
                begin
                    pick = i;
                end
            end
        end
        return (pick < 0) ? '0 : client_vec_t'(1) << pick;
    endfunction

    assign pred_gnt = predict_grant(req, have_last, last_winner);

    // Grant one cycle after the request sample, output one cycle after the grant
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            have_last   <= 1'b0;
            last_winner <= '0;
            exp_gnt     <= '0;
            exp_valid   <= 1'b0;
            exp_client  <= '0;
            exp_data    <= '0;
        end
        else
        begin
            exp_gnt   <= pred_gnt;
            have_last <= |req;
            if (|req)
            begin
                last_winner <= index_of(pred_gnt);
            end
            exp_valid <= |exp_gnt;
            if (|exp_gnt)
            begin
                exp_client <= index_of(exp_gnt);
                exp_data   <= req_data[index_of(exp_gnt)*DATA_W +: DATA_W];
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    a_reset_quiet: assert property (@(negedge clk) !rst_n |-> (gnt == '0 && !out_valid))
    else
    begin
        error_count++;
        $display("Error: %s gnt/out_valid expected 0/0 actual %b/%b",
                 test_name, $sampled(gnt), $sampled(out_valid));
    end

    a_gnt: assert property (@(posedge clk) disable iff (!rst_n) gnt == exp_gnt)
    else
    begin
        error_count++;
        $display("Error: %s gnt expected %b actual %b",
                 test_name, $sampled(exp_gnt), $sampled(gnt));
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
    else
    begin
        error_count++;
        $display("Error: %s out_valid expected %b actual %b",
                 test_name, $sampled(exp_valid), $sampled(out_valid));
    end

    a_client: assert property (@(posedge clk) disable iff (!rst_n) out_client == exp_client)
    else
    begin
        error_count++;
        $display("Error: %s out_client expected %0d actual %0d",
                 test_name, $sampled(exp_client), $sampled(out_client));
    end

    a_data: assert property (@(posedge clk) disable iff (!rst_n) out_data == exp_data)
    else
    begin
        error_count++;
        $display("Error: %s out_data expected %h actual %h",
                 test_name, $sampled(exp_data), $sampled(out_data));
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    // Slice k holds a cycle tag and the client number
    function automatic logic [FLAT_W-1:0] tagged_payload(input int tag);
        logic [FLAT_W-1:0] flat;
        for (int k = 0; k < NUM_CLIENTS; k++)
        begin
            flat[k*DATA_W +: DATA_W] = {8'(tag), 8'(k)};
        end
        return flat;
    endfunction

    task automatic drive_cycle(input client_vec_t r, input logic [FLAT_W-1:0] d);
        @(negedge clk);
        req      = r;
        req_data = d;
    endtask

    // Enough quiet cycles to drain grant and output stages
    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, tagged_payload(cycle_count));
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("Test %s: pass", test_name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic random_cycle();
        client_vec_t       r;
        logic [FLAT_W-1:0] d;
        rng_state = lcg_next(rng_state);
        r = client_vec_t'(rng_state[30:23]);
        // Roughly one cycle in sixteen goes idle
        if (rng_state[6:3] == 4'd0)
        begin
            r = '0;
        end
        for (int k = 0; k < NUM_CLIENTS; k++)
        begin
            rng_state = lcg_next(rng_state);
            d[k*DATA_W +: DATA_W] = rng_state[31:16];
        end
        drive_cycle(r, d);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial
    begin
        rst_n    = 1'b0;
        req      = '0;
        req_data = '0;

        start_test("reset values");
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        // Two requesters on the first cycle out of reset, client 5 wins at once
        req      = client_vec_t'(8'h24);
        req_data = tagged_payload(cycle_count);
        idle_cycles(2);
        end_test();

        start_test("single requester");
        repeat (10) drive_cycle(client_vec_t'(8'h08), tagged_payload(cycle_count));
        idle_cycles(3);
        end_test();

        start_test("full rotation");
        repeat (20) drive_cycle(client_vec_t'(8'hff), tagged_payload(cycle_count));
        idle_cycles(3);
        end_test();

        // Client 5 wins, idle, then client 5 again before client 2
        start_test("idle restart");
        drive_cycle(client_vec_t'(8'h24), tagged_payload(cycle_count));
        drive_cycle('0, tagged_payload(cycle_count));
        repeat (2) drive_cycle(client_vec_t'(8'h24), tagged_payload(cycle_count));
        idle_cycles(3);
        end_test();

        start_test("random traffic");
        repeat (300) random_cycle();
        idle_cycles(3);
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, value errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_shared_port_arbiter

// File: filelist.f
source/arb_pkg.sv
source/leading_one_detector.sv
source/round_robin_arbiter.sv
source/grant_data_mux.sv
source/shared_port_arbiter.sv
verification/tb_shared_port_arbiter.sv

// File: Bender.yml
package:
  name: shared_port_arbiter

sources:
  # Package first, then leaf modules up to the top level
  - source/arb_pkg.sv
  - source/leading_one_detector.sv
  - source/round_robin_arbiter.sv
  - source/grant_data_mux.sv
  - source/shared_port_arbiter.sv

  # Testbench, top module tb_shared_port_arbiter
  - target: test
    files:
      - verification/tb_shared_port_arbiter.sv
